// File: all.f
+incdir+rtl
rtl/persona_reg_pkg.sv
rtl/pattern_pkg.sv
rtl/ddr_word_ram.sv
rtl/access_counters.sv
rtl/pattern_datapath.sv
rtl/access_sequencer.sv
rtl/ddr_access_persona_controller.sv
rtl/ddr_access_persona_top.sv
tests/tb_ddr_access_persona.sv

// File: rtl/access_counters.sv
/*
 * Address counter and busy cycle counter
 * Walks the run range and counts every cycle the persona is busy
 */
`timescale 1ns/100ps

module access_counters (
   input  logic        clk,
   input  logic        pr_logic_rst,
   input  logic        clr_io_reg,
   input  logic [31:0] mem_addr,
   input  logic [31:0] final_address,
   input  logic        addr_load,
   input  logic        addr_step,
   input  logic        busy_reg,
   output logic [31:0] cur_addr,
   output logic        addr_last,
   output logic [31:0] performance_cntr
);

   // While idle the check is on the start address itself, which catches an empty range
   // During a pass it looks one step ahead so the pass ends on the final word
   assign addr_last = busy_reg ? ((cur_addr + 32'd1) == final_address)
                               : (mem_addr == final_address);

   // Load wins over step when a pass ends and the next one begins
   always_ff @(posedge clk) begin
      if (pr_logic_rst) begin
         cur_addr <= 32'h0;
      end else if (addr_load) begin
         cur_addr <= mem_addr;
      end else if (addr_step) begin
         cur_addr <= cur_addr + 32'd1;
      end
   end

   // Busy cycle count, cleared by the host and otherwise kept across runs
   always_ff @(posedge clk) begin
      if (pr_logic_rst || clr_io_reg) begin
         performance_cntr <= 32'h0;
      end else if (busy_reg) begin
         performance_cntr <= performance_cntr + 32'd1;
      end
   end

endmodule

// File: rtl/access_sequencer.sv
/*
 * Run sequencer for the DDR access persona
 * Steps through a write pass, a read pass with one drain cycle and a done cycle
 */
`timescale 1ns/100ps

module access_sequencer
   import persona_reg_pkg::*;
(
   input  logic          clk,
   input  logic          pr_logic_rst,
   input  logic          start_operation,
   input  logic          read_only,
   input  logic          addr_last,
   output logic          clear_start_operation,
   output logic          ddr_access_completed,
   output logic          busy_reg,
   output access_phase_t phase,
   output logic          addr_load,
   output logic          addr_step,
   output logic          mem_we,
   output logic          pattern_step,
   output logic          sum_en
);

   // Set for the single cycle after the last read, while read data is still in flight
   logic drain_q;
   // High on every cycle that issues a memory read
   logic rd_issue;

   assign rd_issue = (phase == READ) && !drain_q;

   // A start request is taken only from IDLE
   assign clear_start_operation = (phase == IDLE) && start_operation;
   // Load from the start address at run start and again between the two passes
   assign addr_load    = clear_start_operation || ((phase == WRITE) && addr_last);
   assign addr_step    = (phase == WRITE) || rd_issue;
   assign mem_we       = (phase == WRITE);
   assign pattern_step = (phase == WRITE);

   assign busy_reg             = (phase != IDLE);
   assign ddr_access_completed = (phase == DONE);

   always_ff @(posedge clk) begin
      if (pr_logic_rst) begin
         phase   <= IDLE;
         drain_q <= 1'b0;
         sum_en  <= 1'b0;
      end else begin
         // Read data returns one cycle after the address
         sum_en <= rd_issue;
         case (phase)
            IDLE: begin
               // In IDLE addr_last flags an empty range, so the run only drains
               if (start_operation) begin
                  if (addr_last) begin
                     phase   <= READ;
                     drain_q <= 1'b1;
                  end else if (read_only) begin
                     phase <= READ;
                  end else begin
                     phase <= WRITE;
                  end
               end
            end
            WRITE: begin
               if (addr_last) begin
                  phase <= READ;
               end
            end
            READ: begin
               if (drain_q) begin
                  phase   <= DONE;
                  drain_q <= 1'b0;
               end else if (addr_last) begin
                  drain_q <= 1'b1;
               end
            end
            default: begin
               phase <= IDLE;
            end
         endcase
      end
   end

endmodule

// File: rtl/ddr_access_defs.svh
/*
 * DDR access persona constants
 * Register file size, identification word and the on-chip memory geometry
 */
`ifndef DDR_ACCESS_DEFS_SVH
`define DDR_ACCESS_DEFS_SVH

// Number of 32-bit register words in each direction between host and logic
`define REG_FILE_IO_SIZE 8

// Identification word read back by the host to recognise this persona
`define PERSONA_ID 32'h0000_00ef

// Word memory standing in for DDR, the low address bits index it so addresses wrap
`define DDR_MEM_WORDS 256
`define DDR_ADDR_BITS 8

`endif

// File: rtl/ddr_access_persona_controller.sv
/*
 * DDR access persona host register block
 * Edge-detects the clear and start controls, captures run parameters
 * and maps results and status into the logic-to-host words
 */
`timescale 1ns/100ps
`include "ddr_access_defs.svh"

module ddr_access_persona_controller
   import persona_reg_pkg::*;
(
   input  logic          clk,
   input  logic          pr_logic_rst,
   input  logic [31:0]   host_cntrl_register,
   input  logic [31:0]   host_pr [0:`REG_FILE_IO_SIZE-1],
   input  logic [31:0]   performance_cntr,
   input  logic [31:0]   checksum,
   input  logic [31:0]   pattern_state,
   input  logic          ddr_access_completed,
   input  logic          clear_start_operation,
   input  logic          busy_reg,
   input  access_phase_t phase,
   output logic          clr_io_reg,
   output logic [31:0]   persona_id,
   output logic [31:0]   pr_host [0:`REG_FILE_IO_SIZE-1],
   output logic          start_operation,
   output logic          load_seed,
   output logic          read_only,
   output logic [31:0]   mem_addr,
   output logic [31:0]   seed,
   output logic [31:0]   final_address
);

   // Captured copies of the clear and start bits and their delayed versions
   logic clear_q;
   logic clear_d;
   logic start_q;
   logic start_d;
   logic start_pulse;

   assign persona_id = `PERSONA_ID;

   // Result words, busy in bit 0 and the phase in bits 2:1 of the status word
   assign pr_host[0] = performance_cntr;
   assign pr_host[1] = {29'h0, phase, busy_reg};
   assign pr_host[2] = checksum;
   assign pr_host[3] = pattern_state;

   // Remaining words are not used by this persona and read as zero
   for (genvar i = 4; i < `REG_FILE_IO_SIZE; i++) begin : g_unused_words
      assign pr_host[i] = 32'h0;
   end

   // Control bits pass a capture stage before edge detection
   always_ff @(posedge clk) begin
      if (pr_logic_rst) begin
         clear_q         <= 1'b0;
         clear_d         <= 1'b0;
         start_q         <= 1'b0;
         start_d         <= 1'b0;
         start_pulse     <= 1'b0;
         clr_io_reg      <= 1'b0;
         start_operation <= 1'b0;
         load_seed       <= 1'b0;
         read_only       <= 1'b0;
      end else begin
         clear_q     <= host_cntrl_register[0];
         clear_d     <= clear_q;
         clr_io_reg  <= clear_q & ~clear_d;
         start_q     <= host_cntrl_register[2];
         start_d     <= start_q;
         start_pulse <= start_q & ~start_d;
         // The request is held until the sequencer takes it or a run completes
         if (start_pulse) begin
            start_operation <= 1'b1;
         end else if (clear_start_operation || ddr_access_completed) begin
            start_operation <= 1'b0;
         end
         load_seed <= host_cntrl_register[1];
         read_only <= host_cntrl_register[3];
      end
   end

   // Run parameters, final_address lags the start address by one cycle
   always_ff @(posedge clk) begin
      mem_addr      <= host_pr[0];
      seed          <= host_pr[1];
      final_address <= mem_addr + host_pr[2];
   end

endmodule

// File: rtl/ddr_access_persona_top.sv
/*
 * DDR access test persona
 * Joins the host register block, sequencer, counters, pattern datapath and memory
 */
`timescale 1ns/100ps
`include "ddr_access_defs.svh"

module ddr_access_persona_top
   import persona_reg_pkg::*;
(
   input  logic        clk,
   input  logic        pr_logic_rst,
   input  logic [31:0] host_cntrl_register,
   input  logic [31:0] host_pr [0:`REG_FILE_IO_SIZE-1],
   output logic [31:0] persona_id,
   output logic [31:0] pr_host [0:`REG_FILE_IO_SIZE-1]
);

   // Host side controls and run parameters
   logic          clr_io_reg;
   logic          start_operation;
   logic          load_seed;
   logic          read_only;
   logic [31:0]   mem_addr;
   logic [31:0]   seed;
   logic [31:0]   final_address;

   // Sequencer strobes and status
   logic          clear_start_operation;
   logic          ddr_access_completed;
   logic          busy_reg;
   access_phase_t phase;
   logic          addr_load;
   logic          addr_step;
   logic          mem_we;
   logic          pattern_step;
   logic          sum_en;

   // Datapath and results
   logic [31:0]   cur_addr;
   logic          addr_last;
   logic [31:0]   performance_cntr;
   logic [31:0]   pattern_state;
   logic [31:0]   checksum;
   logic [31:0]   rd_data;

   ddr_access_persona_controller u_controller (.*);

   access_sequencer u_sequencer (.*);

   access_counters u_counters (.*);

   pattern_datapath u_datapath (.*);

   // Only the low address bits reach the memory, so the range wraps
   ddr_word_ram u_ram (
      .clk     (clk),
      .we      (mem_we),
      .addr    (cur_addr[`DDR_ADDR_BITS-1:0]),
      .wr_data (pattern_state),
      .rd_data (rd_data)
   );

endmodule

// File: rtl/ddr_word_ram.sv
/*
 * Single-port word memory standing in for DDR
 * Synchronous write and a one-cycle registered read
 */
`timescale 1ns/100ps
`include "ddr_access_defs.svh"

module ddr_word_ram (
   input  logic                      clk,
   input  logic                      we,
   input  logic [`DDR_ADDR_BITS-1:0] addr,
   input  logic [31:0]               wr_data,
   output logic [31:0]               rd_data
);

   logic [31:0] mem [0:`DDR_MEM_WORDS-1];

   // A read during a write returns the old word
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wr_data;
      end
      rd_data <= mem[addr];
   end

endmodule

// File: rtl/pattern_datapath.sv
/*
 * Pattern and checksum datapath
 * LFSR pattern register for write data and a wrapping sum of read data
 */
`timescale 1ns/100ps

module pattern_datapath
   import pattern_pkg::*;
(
   input  logic        clk,
   input  logic        pr_logic_rst,
   input  logic        clr_io_reg,
   input  logic        load_seed,
   input  logic [31:0] seed,
   input  logic        pattern_step,
   input  logic        sum_en,
   input  logic [31:0] rd_data,
   output logic [31:0] pattern_state,
   output logic [31:0] checksum
);

   // The seed is a level, so the state holds the seed for as long as it is asserted
   // Without a load the state persists between runs
   always_ff @(posedge clk) begin
      if (pr_logic_rst) begin
         pattern_state <= 32'h0;
      end else if (load_seed) begin
         pattern_state <= seed;
      end else if (pattern_step) begin
         pattern_state <= pattern_next(pattern_state);
      end
   end

   // Accumulates across runs until the host clears it
   always_ff @(posedge clk) begin
      if (pr_logic_rst || clr_io_reg) begin
         checksum <= 32'h0;
      end else if (sum_en) begin
         checksum <= checksum + rd_data;
      end
   end

endmodule

// File: rtl/pattern_pkg.sv
/*
 * Pattern data definitions
 * Galois LFSR step shared by the datapath and the reference model
 */
package pattern_pkg;

   // Taps 32, 22, 2, 1 in right-shifting Galois form
   localparam logic [31:0] PATTERN_TAPS = 32'h8020_0003;

   // Next pattern word, a zero word stays zero
   function automatic logic [31:0] pattern_next(input logic [31:0] word);
      logic [31:0] shifted;
      shifted = word >> 1;
      return word[0] ? (shifted ^ PATTERN_TAPS) : shifted;
   endfunction

endpackage

// File: rtl/persona_reg_pkg.sv
/*
 * Register and status description for the DDR access persona
 * Holds the run phase reported to the host in the status word
 */
package persona_reg_pkg;

   // Phase of a run as seen by the host in status bits 2:1
   // The drain cycle after the last read reports as READ
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      WRITE = 2'd1,
      READ  = 2'd2,
      DONE  = 2'd3
   } access_phase_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
# Builds the DDR access persona testbench with Verilator and runs it
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f all.f --top-module tb_ddr_access_persona -o sim_ddr_access \
   && ./obj_dir/sim_ddr_access | tee sim.log \
   || { echo "Build or simulation did not complete"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation reported failure"; exit 1; } \
   || echo "Simulation reported no failure"

// File: tests/tb_ddr_access_persona.sv
/*
 * Testbench for the DDR access persona
 * Random write and read-only runs checked against a memory, LFSR and counter model
 */
`timescale 1ns/100ps
`include "ddr_access_defs.svh"

module tb_ddr_access_persona;

   // Longest run is 82 busy cycles, so this leaves ample margin
   localparam int WAIT_LIMIT = 300;

   logic        clk;
   logic        pr_logic_rst;
   logic [31:0] host_cntrl_register;
   logic [31:0] host_pr [0:`REG_FILE_IO_SIZE-1];
   logic [31:0] persona_id;
   logic [31:0] pr_host [0:`REG_FILE_IO_SIZE-1];

   // Reference model of the memory, pattern register and result counters
   logic [31:0] model_mem [0:`DDR_MEM_WORDS-1];
   logic [31:0] exp_pattern;
   logic [31:0] exp_checksum;
   logic [31:0] exp_busy;
   logic [31:0] rng_state;
   int          errors;
   int          timeouts;

   ddr_access_persona_top dut (
      .clk                 (clk),
      .pr_logic_rst        (pr_logic_rst),
      .host_cntrl_register (host_cntrl_register),
      .host_pr             (host_pr),
      .persona_id          (persona_id),
      .pr_host             (pr_host)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Xorshift32 step with shifts 13, 17 and 5
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_random(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r = rng_state;
   endtask

   // Right-shifting Galois LFSR whose taps 32, 22, 2 and 1 land on bits 31, 21, 1 and 0
   function automatic logic [31:0] lfsr_advance(input logic [31:0] x);
      logic [31:0] y;
      y = {1'b0, x[31:1]};
      if (x[0]) begin
         y = y ^ 32'h8020_0003;
      end
      return y;
   endfunction

   task automatic check_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic report_and_finish();
      $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   // Polls the busy bit on falling edges until it reaches the wanted level
   task automatic wait_busy(input logic level);
      int cycles;
      cycles = 0;
      while (pr_host[1][0] !== level && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (pr_host[1][0] !== level) begin
         timeouts++;
         $display("Timeout: busy never reached %b within %0d cycles", level, WAIT_LIMIT);
      end
   endtask

   // Seed is a level input, held for a few cycles so the pattern register takes it
   task automatic load_seed_word(input logic [31:0] s);
      @(posedge clk);
      host_pr[1] <= s;
      host_cntrl_register[1] <= 1'b1;
      repeat (3) @(posedge clk);
      host_cntrl_register[1] <= 1'b0;
      repeat (2) @(negedge clk);
      exp_pattern = s;
      check_word("pattern after seed load", pr_host[3], exp_pattern);
   endtask

   task automatic clear_results();
      @(posedge clk);
      host_cntrl_register[0] <= 1'b1;
      @(posedge clk);
      host_cntrl_register[0] <= 1'b0;
      repeat (4) @(negedge clk);
      exp_checksum = 32'h0;
      exp_busy = 32'h0;
      check_word("checksum after clear", pr_host[2], exp_checksum);
      check_word("busy count after clear", pr_host[0], exp_busy);
      check_word("pattern after clear", pr_host[3], exp_pattern);
   endtask

   // One run, optionally with a second start pulsed while the first is still busy
   task automatic run_access(input logic [31:0] addr, input logic [31:0] n,
                             input logic ro, input logic extra_start);
      logic [7:0] idx;
      int         i;
      if (timeouts != 0) begin
         return;
      end
      @(posedge clk);
      host_pr[0] <= addr;
      host_pr[2] <= n;
      host_cntrl_register[3] <= ro;
      // Address, final address and read-only flag settle through their registers
      repeat (3) @(posedge clk);
      host_cntrl_register[2] <= 1'b1;
      @(posedge clk);
      host_cntrl_register[2] <= 1'b0;
      wait_busy(1'b1);
      if (timeouts != 0) begin
         return;
      end
      if (extra_start) begin
         @(posedge clk);
         host_cntrl_register[2] <= 1'b1;
         @(posedge clk);
         host_cntrl_register[2] <= 1'b0;
      end
      wait_busy(1'b0);
      if (timeouts != 0) begin
         return;
      end
      // Write pass stores N successive patterns, then the read pass sums the same range
      if (!ro) begin
         for (i = 0; i < n; i++) begin
            idx = 8'(addr + i);
            model_mem[idx] = exp_pattern;
            exp_pattern = lfsr_advance(exp_pattern);
         end
      end
      for (i = 0; i < n; i++) begin
         idx = 8'(addr + i);
         exp_checksum = exp_checksum + model_mem[idx];
      end
      exp_busy = exp_busy + (ro ? n + 32'd2 : 2 * n + 32'd2);
      // A few idle cycles show that no extra run was started
      repeat (6) @(negedge clk);
      check_word("busy cycle count", pr_host[0], exp_busy);
      check_word("status word", pr_host[1], 32'h0);
      check_word("checksum", pr_host[2], exp_checksum);
      check_word("pattern state", pr_host[3], exp_pattern);
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] addr;
      logic [31:0] n;
      logic [31:0] off;
      int          k;
      pr_logic_rst <= 1'b1;
      host_cntrl_register <= 32'h0;
      for (k = 0; k < `REG_FILE_IO_SIZE; k++) begin
         host_pr[k] <= 32'h0;
      end
      errors = 0;
      timeouts = 0;
      rng_state = 32'h38ba86c1;
      exp_pattern = 32'h0;
      exp_checksum = 32'h0;
      exp_busy = 32'h0;
      repeat (2) @(posedge clk);
      pr_logic_rst <= 1'b0;
      @(negedge clk);

      // Identification word and cleared result words out of reset
      check_word("persona id", persona_id, `PERSONA_ID);
      for (k = 0; k < `REG_FILE_IO_SIZE; k++) begin
         check_word("result word after reset", pr_host[k], 32'h0);
      end

      next_random(r);
      load_seed_word(r);

      // Each normal run is followed by a read-only run inside the range just written
      for (k = 0; k < 8; k++) begin
         next_random(addr);
         next_random(r);
         n = r % 32'd41;
         run_access(addr, n, 1'b0, 1'b0);
         next_random(r);
         off = r % (n + 32'd1);
         next_random(r);
         run_access(addr + off, r % (n - off + 32'd1), 1'b1, 1'b0);
      end

      // Range that wraps past the top of the memory, read back through a different upper address
      next_random(r);
      load_seed_word(r);
      next_random(r);
      run_access({r[31:8], 8'hf4}, 32'd24, 1'b0, 1'b0);
      next_random(r);
      run_access({r[31:8], 8'hf8}, 32'd16, 1'b1, 1'b0);

      // A start pulsed during a long run must not launch a second run
      next_random(addr);
      next_random(r);
      run_access(addr, 32'd20 + r % 32'd21, 1'b0, 1'b1);

      // Clear, then accumulate again from zero
      clear_results();
      next_random(addr);
      next_random(r);
      run_access(addr, r % 32'd41, 1'b0, 1'b0);

      report_and_finish();
   end

endmodule
